/* src.f */
common/bt_pkt_pkg.sv
common/arq_cfg_pkg.sv
logic/rx_hdr_classify.sv
logic/arq_event_fifo.sv
arq/arq_state.sv
logic/bt_arq_top.sv
dv/tb_bt_arq.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_bt_arq
RTL_TOP    := bt_arq_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_bt_arq.sv */
//**************************************************************************
// table of directed steps, then a random burst checked against a model
// rx_buf_free is held at 1 through the burst, since the DUT samples it on pop
//**************************************************************************
`timescale 1ns/1ps

module tb_bt_arq
  import bt_pkt_pkg::*;
  import arq_cfg_pkg::*;
;

  localparam int clk_period = 8;
  localparam int n_steps    = 20;
  localparam int burst_len  = 40;
  localparam logic [1:0] op_rx     = 2'd0;
  localparam logic [1:0] op_reset  = 2'd1;
  localparam logic [1:0] op_commit = 2'd2;

  typedef struct packed {
    logic [1:0]           op;
    logic [lt_addr_w-1:0] lt;
    logic [pktype_w-1:0]  pktype;
    logic                 seqn;
    logic                 arqn;
    logic                 flow;
    logic                 hdr;
    logic                 crc;
    logic                 buf_free;
    logic [lt_addr_w-1:0] tx_lt;
    logic [7:0]           exp_arqn;
    logic [7:0]           exp_seqn;
    logic [7:0]           exp_flow;
    logic                 exp_new;
  } step_t;

  logic                 clk_6M = 1'b0;
  logic                 rstz;
  logic                 rx_valid;
  logic                 rx_ready;
  logic [lt_addr_w-1:0] rx_lt_addr;
  logic [pktype_w-1:0]  rx_pktype;
  logic                 rx_seqn;
  logic                 rx_arqn;
  logic                 rx_flow;
  logic                 rx_hdr_good;
  logic                 rx_crc_good;
  logic                 rx_buf_free;
  logic                 link_reset;
  logic [lt_addr_w-1:0] reset_lt_addr;
  logic [lt_addr_w-1:0] tx_lt_addr;
  logic                 tx_commit;
  logic [num_links-1:0] tx_arqn;
  logic [num_links-1:0] tx_seqn;
  logic [num_links-1:0] peer_flow;
  logic                 send_new;
  logic                 send_old;

  // reference model state for the burst
  logic [num_links-1:0] m_arqn;
  logic [num_links-1:0] m_so;
  logic [num_links-1:0] m_pa;
  logic [num_links-1:0] m_pf;
  logic [num_links-1:0] m_ts;

  // op, lt, type, seqn, arqn, flow, hdr, crc, buf | tx_lt, arqn, tx_seqn, flow, send_new
  step_t steps [n_steps] = '{
    // first accept, duplicates, duplicate with bad crc
    '{op_rx, 3'd1, pk_dm1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 3'd1, 8'h02, 8'h00, 8'hff, 1'b0},
    '{op_rx, 3'd1, pk_dm1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 3'd1, 8'h02, 8'h00, 8'hff, 1'b0},
    '{op_rx, 3'd1, pk_dh1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 3'd1, 8'h02, 8'h00, 8'hff, 1'b0},
    // new seqn rejected by crc, then by full buffer
    '{op_rx, 3'd2, pk_dm3, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 3'd2, 8'h02, 8'h00, 8'hff, 1'b0},
    '{op_rx, 3'd1, pk_dm1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 3'd1, 8'h00, 8'h00, 8'hff, 1'b0},
    '{op_rx, 3'd1, pk_dm1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 3'd1, 8'h02, 8'h00, 8'hff, 1'b0},
    // poll keeps the nak on link 2
    '{op_rx, 3'd2, pk_poll, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 3'd2, 8'h02, 8'h00, 8'hff, 1'b0},
    '{op_rx, 3'd3, pk_dh5, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 3'd3, 8'h0a, 8'h00, 8'hff, 1'b0},
    // undefined type naks, header fail clears all and leaves peer state
    '{op_rx, 3'd4, 4'h5, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 3'd4, 8'h0a, 8'h00, 8'hef, 1'b0},
    '{op_rx, 3'd5, pk_dm1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 3'd5, 8'h00, 8'h00, 8'hef, 1'b0},
    // peer ack and flow gate the tx seqn toggle
    '{op_rx, 3'd6, pk_null, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 3'd6, 8'h00, 8'h00, 8'hef, 1'b1},
    '{op_commit, 3'd0, pk_null, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd6, 8'h00, 8'h40, 8'hef, 1'b1},
    '{op_rx, 3'd6, pk_null, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 3'd6, 8'h00, 8'h40, 8'haf, 1'b0},
    '{op_commit, 3'd0, pk_null, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd6, 8'h00, 8'h40, 8'haf, 1'b0},
    '{op_rx, 3'd6, pk_poll, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 3'd6, 8'h00, 8'h40, 8'hef, 1'b1},
    '{op_rx, 3'd3, pk_dm1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 3'd3, 8'h08, 8'h40, 8'hef, 1'b1},
    '{op_commit, 3'd0, pk_null, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd3, 8'h08, 8'h48, 8'hef, 1'b1},
    // single link resets, link 3 untouched
    '{op_reset, 3'd6, pk_null, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd6, 8'h08, 8'h08, 8'hef, 1'b0},
    '{op_reset, 3'd4, pk_null, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd3, 8'h08, 8'h08, 8'hff, 1'b1},
    '{op_rx, 3'd3, pk_dm1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 3'd3, 8'h08, 8'h08, 8'hff, 1'b1}
  };

  bt_arq_top bt_arq_top_inst (.*);

  always #(clk_period / 2) clk_6M = ~clk_6M;

  task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  // acl data codes, aux1 included
  function automatic logic is_data(input logic [pktype_w-1:0] t);
    case (t)
      4'd3, 4'd4, 4'd8, 4'd9, 4'd10, 4'd11, 4'd14, 4'd15:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  // reference arq rules 1 to 6 plus peer capture
  task automatic model_rx(input logic [lt_addr_w-1:0] lt, input logic [pktype_w-1:0] t,
                          input logic seqn, input logic arqn, input logic flow,
                          input logic hdr, input logic crc, input logic buf_free);
    if (!hdr)
      m_arqn = '0;
    else
    begin
      m_pa[lt] = arqn;
      m_pf[lt] = flow;
      if (is_data(t))
      begin
        if (seqn == m_so[lt])
          m_arqn[lt] = 1'b1;
        else if (crc && buf_free)
        begin
          m_so[lt]   = seqn;
          m_arqn[lt] = 1'b1;
        end
        else
          m_arqn[lt] = 1'b0;
      end
      // null, poll and fhs keep arqn, anything else naks
      else if (t > 4'd2)
        m_arqn[lt] = 1'b0;
    end
  endtask

  task automatic model_reset(input logic [lt_addr_w-1:0] lt);
    m_arqn[lt] = 1'b0;
    m_so[lt]   = 1'b0;
    m_ts[lt]   = 1'b0;
    m_pa[lt]   = 1'b0;
    m_pf[lt]   = 1'b1;
  endtask

  // starts and ends on a falling edge
  task automatic apply_step(input int idx, input step_t s);
    tx_lt_addr = s.tx_lt;
    case (s.op)
      op_rx:
      begin
        rx_lt_addr  = s.lt;
        rx_pktype   = s.pktype;
        rx_seqn     = s.seqn;
        rx_arqn     = s.arqn;
        rx_flow     = s.flow;
        rx_hdr_good = s.hdr;
        rx_crc_good = s.crc;
        rx_buf_free = s.buf_free;
        rx_valid    = 1'b1;
        while (!rx_ready)
          @(negedge clk_6M);
        @(negedge clk_6M);
        rx_valid = 1'b0;
      end
      op_reset:
      begin
        reset_lt_addr = s.lt;
        link_reset    = 1'b1;
        @(negedge clk_6M);
        link_reset = 1'b0;
      end
      default:
      begin
        tx_commit = 1'b1;
        @(negedge clk_6M);
        tx_commit = 1'b0;
      end
    endcase
    repeat (4) @(negedge clk_6M);
    check_value($sformatf("step %0d tx_arqn", idx), tx_arqn, s.exp_arqn);
    check_value($sformatf("step %0d tx_seqn", idx), tx_seqn, s.exp_seqn);
    check_value($sformatf("step %0d peer_flow", idx), peer_flow, s.exp_flow);
    check_value($sformatf("step %0d send_new", idx), {7'd0, send_new}, {7'd0, s.exp_new});
    // retransmit whenever no new payload may go
    check_value($sformatf("step %0d send_old", idx), {7'd0, send_old}, {7'd0, !s.exp_new});
  endtask

  // random back-to-back events on links 0..6, link 7 reset stalls the pop
  task automatic run_burst();
    int  sent;
    int  cyc;
    logic fire;
    sent = 0;
    cyc  = 0;
    fire = 1'b0;
    rx_buf_free = 1'b1;
    while (sent < burst_len)
    begin
      @(negedge clk_6M);
      if (fire)
      begin
        model_rx(rx_lt_addr, rx_pktype, rx_seqn, rx_arqn, rx_flow, rx_hdr_good,
                 rx_crc_good, rx_buf_free);
        sent++;
      end
      reset_lt_addr = 3'd7;
      link_reset    = (cyc >= 10 && cyc < 20);
      if (cyc == 10)
        model_reset(3'd7);
      // hold fields while the source is stalled
      if (!rx_valid || fire)
      begin
        if (sent < burst_len && ($urandom % 4) != 0)
        begin
          rx_valid    = 1'b1;
          rx_lt_addr  = 3'($urandom % 7);
          rx_pktype   = 4'($urandom);
          rx_seqn     = 1'($urandom);
          rx_arqn     = 1'($urandom);
          rx_flow     = 1'($urandom);
          rx_hdr_good = ($urandom % 8) != 0;
          rx_crc_good = ($urandom % 4) != 0;
        end
        else
          rx_valid = 1'b0;
      end
      fire = rx_valid && rx_ready;
      cyc++;
    end
    link_reset = 1'b0;
    rx_valid   = 1'b0;
  endtask

  initial
  begin
    void'($urandom(36259));
    rstz          = 1'b0;
    rx_valid      = 1'b0;
    rx_lt_addr    = '0;
    rx_pktype     = pk_null;
    rx_seqn       = 1'b0;
    rx_arqn       = 1'b0;
    rx_flow       = 1'b0;
    rx_hdr_good   = 1'b1;
    rx_crc_good   = 1'b1;
    rx_buf_free   = 1'b1;
    link_reset    = 1'b0;
    reset_lt_addr = '0;
    tx_lt_addr    = '0;
    tx_commit     = 1'b0;
    repeat (4) @(negedge clk_6M);
    rstz = 1'b1;
    // all links nak, flow on, retransmit side selected
    for (int i = 0; i < num_links; i++)
    begin
      tx_lt_addr = 3'(i);
      @(negedge clk_6M);
      check_value("reset rx_ready", {7'd0, rx_ready}, 8'h01);
      check_value("reset tx_arqn", tx_arqn, 8'h00);
      check_value("reset tx_seqn", tx_seqn, 8'h00);
      check_value("reset peer_flow", peer_flow, 8'hff);
      check_value("reset send_old", {7'd0, send_old}, 8'h01);
    end
    for (int i = 0; i < n_steps; i++)
      apply_step(i, steps[i]);
    // clean start for the model
    for (int i = 0; i < num_links; i++)
    begin
      reset_lt_addr = 3'(i);
      link_reset    = 1'b1;
      @(negedge clk_6M);
    end
    link_reset = 1'b0;
    m_arqn = '0;
    m_so   = '0;
    m_pa   = '0;
    m_pf   = '1;
    m_ts   = '0;
    run_burst();
    // drain classifier stage and fifo
    repeat (fifo_depth + 4) @(negedge clk_6M);
    check_value("burst tx_arqn", tx_arqn, m_arqn);
    check_value("burst tx_seqn", tx_seqn, m_ts);
    check_value("burst peer_flow", peer_flow, m_pf);
    for (int i = 0; i < num_links; i++)
    begin
      tx_lt_addr = 3'(i);
      @(negedge clk_6M);
      check_value($sformatf("burst send_new link %0d", i), {7'd0, send_new},
                  {7'd0, m_pa[i] & m_pf[i]});
    end
    $display("TB PASSED");
    $finish;
  end

  // watchdog sized from table and burst length
  initial
  begin
    #((n_steps * 20 + burst_len * 10 + 100) * clk_period);
    $display("timeout: the run did not reach its end in the allowed time");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* logic/bt_arq_top.sv */
//**************************************************************************
// rx header to arq state, three clocks without back-pressure
//**************************************************************************
`timescale 1ns/1ps

module bt_arq_top
  import bt_pkt_pkg::*;
  import arq_cfg_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  input  logic [lt_addr_w-1:0] rx_lt_addr,
  input  logic [pktype_w-1:0]  rx_pktype,
  input  logic                 rx_seqn,
  input  logic                 rx_arqn,
  input  logic                 rx_flow,
  input  logic                 rx_hdr_good,
  input  logic                 rx_crc_good,
  input  logic                 rx_buf_free,
  input  logic                 link_reset,
  input  logic [lt_addr_w-1:0] reset_lt_addr,
  input  logic [lt_addr_w-1:0] tx_lt_addr,
  input  logic                 tx_commit,
  output logic [num_links-1:0] tx_arqn,
  output logic [num_links-1:0] tx_seqn,
  output logic [num_links-1:0] peer_flow,
  output logic                 send_new,
  output logic                 send_old
);

  // classifier to fifo
  logic             cls_valid;
  logic             cls_ready;
  logic [evt_w-1:0] cls_word;
  // fifo to arq state
  logic             evt_valid;
  logic             evt_ready;
  logic [evt_w-1:0] evt_word;

  rx_hdr_classify classify_inst (
    .clk_6M      (clk_6M),
    .rstz        (rstz),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .rx_lt_addr  (rx_lt_addr),
    .rx_pktype   (rx_pktype),
    .rx_seqn     (rx_seqn),
    .rx_arqn     (rx_arqn),
    .rx_flow     (rx_flow),
    .rx_hdr_good (rx_hdr_good),
    .rx_crc_good (rx_crc_good),
    .cls_valid   (cls_valid),
    .cls_ready   (cls_ready),
    .cls_word    (cls_word)
  );

  arq_event_fifo fifo_inst (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .in_valid  (cls_valid),
    .in_ready  (cls_ready),
    .in_word   (cls_word),
    .out_valid (evt_valid),
    .out_ready (evt_ready),
    .out_word  (evt_word)
  );

  arq_state state_inst (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .evt_valid     (evt_valid),
    .evt_ready     (evt_ready),
    .evt_word      (evt_word),
    .rx_buf_free   (rx_buf_free),
    .link_reset    (link_reset),
    .reset_lt_addr (reset_lt_addr),
    .tx_lt_addr    (tx_lt_addr),
    .tx_commit     (tx_commit),
    .tx_arqn       (tx_arqn),
    .tx_seqn       (tx_seqn),
    .peer_flow     (peer_flow),
    .send_new      (send_new),
    .send_old      (send_old)
  );

endmodule

/* arq/arq_state.sv */
//**************************************************************************
// slave-side acl arq state, one bit per link per field
// link_reset stalls the event pop for that cycle and wins over tx_commit
//**************************************************************************
`timescale 1ns/1ps

module arq_state
  import bt_pkt_pkg::*;
  import arq_cfg_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 evt_valid,
  output logic                 evt_ready,
  input  logic [evt_w-1:0]     evt_word,
  input  logic                 rx_buf_free,
  input  logic                 link_reset,
  input  logic [lt_addr_w-1:0] reset_lt_addr,
  input  logic [lt_addr_w-1:0] tx_lt_addr,
  input  logic                 tx_commit,
  output logic [num_links-1:0] tx_arqn,
  output logic [num_links-1:0] tx_seqn,
  output logic [num_links-1:0] peer_flow,
  output logic                 send_new,
  output logic                 send_old
);

  logic [num_links-1:0] seqn_old;
  logic [num_links-1:0] peer_arqn;
  logic                 ev_take;
  logic [lt_addr_w-1:0] ev_lt;
  evt_kind_t            ev_kind;
  logic                 ev_seqn;
  logic                 ev_arqn;
  logic                 ev_flow;
  logic                 ev_crc;
  logic                 ev_dup;

  // no pop while a link is being reset
  assign evt_ready = !link_reset;
  assign ev_take   = evt_valid && evt_ready;

  // word unpack
  assign ev_lt   = evt_word[ev_lt_lsb +: lt_addr_w];
  assign ev_kind = evt_kind_t'(evt_word[ev_kind_lsb +: kind_w]);
  assign ev_seqn = evt_word[ev_seqn_bit];
  assign ev_arqn = evt_word[ev_arqn_bit];
  assign ev_flow = evt_word[ev_flow_bit];
  assign ev_crc  = evt_word[ev_crc_bit];

  // same seqn as last accepted, payload already held
  assign ev_dup = ev_seqn == seqn_old[ev_lt];

  // rx side, arqn and seqn_old
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      tx_arqn  <= '0;
      seqn_old <= '0;
    end
    else if (link_reset)
    begin
      tx_arqn[reset_lt_addr]  <= 1'b0;
      seqn_old[reset_lt_addr] <= 1'b0;
    end
    else if (ev_take)
    begin
      case (ev_kind)
        // any address may have been missed, nak them all
        ev_hdr_fail:
          tx_arqn <= '0;
        ev_data:
        begin
          if (ev_dup)
            tx_arqn[ev_lt] <= 1'b1;
          else if (ev_crc && rx_buf_free)
          begin
            seqn_old[ev_lt] <= ev_seqn;
            tx_arqn[ev_lt]  <= 1'b1;
          end
          else
            tx_arqn[ev_lt] <= 1'b0;
        end
        ev_bad_type:
          tx_arqn[ev_lt] <= 1'b0;
        // null, poll, fhs keep the previous ack
        default:
          ;
      endcase
    end
  end

  // peer arqn and flow as last heard on each link
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      peer_arqn <= '0;
      peer_flow <= '1;
    end
    else if (link_reset)
    begin
      peer_arqn[reset_lt_addr] <= 1'b0;
      peer_flow[reset_lt_addr] <= 1'b1;
    end
    else if (ev_take && ev_kind != ev_hdr_fail)
    begin
      peer_arqn[ev_lt] <= ev_arqn;
      peer_flow[ev_lt] <= ev_flow;
    end
  end

  // new payload only on ack with flow go
  assign send_new = peer_arqn[tx_lt_addr] && peer_flow[tx_lt_addr];
  assign send_old = !send_new;

  // tx seqn flips once per committed new payload
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      tx_seqn <= '0;
    else
    begin
      if (tx_commit && send_new)
        tx_seqn[tx_lt_addr] <= ~tx_seqn[tx_lt_addr];
      // later assignment wins on the same link
      if (link_reset)
        tx_seqn[reset_lt_addr] <= 1'b0;
    end
  end

endmodule

/* logic/arq_event_fifo.sv */
//**************************************************************************
// synchronous event fifo, no fall-through
// a word pushed on one clock shows on out_valid from the next
//**************************************************************************
`timescale 1ns/1ps

module arq_event_fifo
  import bt_pkt_pkg::*;
  import arq_cfg_pkg::*;
(
  input  logic             clk_6M,
  input  logic             rstz,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [evt_w-1:0] in_word,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [evt_w-1:0] out_word
);

  logic [evt_w-1:0] mem [fifo_depth];
  logic [fifo_aw-1:0] wr_ptr;
  logic [fifo_aw-1:0] rd_ptr;
  logic [fifo_aw:0]   count;
  logic               push;
  logic               pop;

  // full and empty straight from the count
  assign in_ready  = count != (fifo_aw+1)'(fifo_depth);
  assign out_valid = count != '0;
  assign out_word  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      // simultaneous push and pop leaves count alone
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk_6M)
  begin
    if (push)
      mem[wr_ptr] <= in_word;
  end

endmodule

/* logic/rx_hdr_classify.sv */
//**************************************************************************
// single register stage, no skid buffer
// rx fields must stay stable while rx_valid is high and rx_ready low
//**************************************************************************
`timescale 1ns/1ps

module rx_hdr_classify
  import bt_pkt_pkg::*;
(
  input  logic                 clk_6M,
  input  logic                 rstz,
  input  logic                 rx_valid,
  output logic                 rx_ready,
  input  logic [lt_addr_w-1:0] rx_lt_addr,
  input  logic [pktype_w-1:0]  rx_pktype,
  input  logic                 rx_seqn,
  input  logic                 rx_arqn,
  input  logic                 rx_flow,
  input  logic                 rx_hdr_good,
  input  logic                 rx_crc_good,
  output logic                 cls_valid,
  input  logic                 cls_ready,
  output logic [evt_w-1:0]     cls_word
);

  evt_kind_t  rx_kind;
  logic       rx_take;

  // stage accepts when empty or draining this cycle
  assign rx_ready = !cls_valid || cls_ready;
  assign rx_take  = rx_valid && rx_ready;

  // type decode, bad header wins over any type
  always_comb
  begin
    if (!rx_hdr_good)
      rx_kind = ev_hdr_fail;
    else
    begin
      case (rx_pktype)
        pk_null, pk_poll, pk_fhs:
          rx_kind = ev_nopay;
        pk_dm1, pk_dh1, pk_dv, pk_aux1, pk_dm3, pk_dh3, pk_dm5, pk_dh5:
          rx_kind = ev_data;
        default:
          rx_kind = ev_bad_type;
      endcase
    end
  end

  // valid flag
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      cls_valid <= 1'b0;
    else if (rx_ready)
      cls_valid <= rx_valid;
  end

  // payload register, held until the fifo takes it
  always_ff @(posedge clk_6M)
  begin
    if (rx_take)
      cls_word <= {rx_lt_addr, rx_kind, rx_seqn, rx_arqn, rx_flow, rx_crc_good,
                   {ev_spare_w{1'b0}}};
  end

endmodule

/* common/arq_cfg_pkg.sv */
//**************************************************************************
// link count and event fifo sizing
// fifo_aw must be log2 of fifo_depth
//**************************************************************************
package arq_cfg_pkg;

  // one bit of per-link state per logical transport address
  localparam int num_links = 8;

  // classified event fifo
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = 2;

endpackage

/* common/bt_pkt_pkg.sv */
//**************************************************************************
// header field widths, packet type codes and classified event word layout
// word bits [1:0] are spare and always written as zero
//**************************************************************************
package bt_pkt_pkg;

  // header field widths
  localparam int lt_addr_w = 3;
  localparam int pktype_w  = 4;

  // no-payload types, fhs counted here too
  localparam logic [pktype_w-1:0] pk_null = 4'h0;
  localparam logic [pktype_w-1:0] pk_poll = 4'h1;
  localparam logic [pktype_w-1:0] pk_fhs  = 4'h2;

  // acl data types, aux1 included
  localparam logic [pktype_w-1:0] pk_dm1  = 4'h3;
  localparam logic [pktype_w-1:0] pk_dh1  = 4'h4;
  localparam logic [pktype_w-1:0] pk_dv   = 4'h8;
  localparam logic [pktype_w-1:0] pk_aux1 = 4'h9;
  localparam logic [pktype_w-1:0] pk_dm3  = 4'ha;
  localparam logic [pktype_w-1:0] pk_dh3  = 4'hb;
  localparam logic [pktype_w-1:0] pk_dm5  = 4'he;
  localparam logic [pktype_w-1:0] pk_dh5  = 4'hf;

  // event kind as seen by the arq state keeper
  localparam int kind_w = 2;

  typedef enum logic [kind_w-1:0] {
    ev_hdr_fail = 2'd0,
    ev_data     = 2'd1,
    ev_nopay    = 2'd2,
    ev_bad_type = 2'd3
  } evt_kind_t;

  // fifo word layout, msb first
  // lt_addr | kind | seqn | arqn | flow | crc_ok | spare
  localparam int evt_w       = 11;
  localparam int ev_lt_lsb   = 8;
  localparam int ev_kind_lsb = 6;
  localparam int ev_seqn_bit = 5;
  localparam int ev_arqn_bit = 4;
  localparam int ev_flow_bit = 3;
  localparam int ev_crc_bit  = 2;
  localparam int ev_spare_w  = 2;

endpackage
